// File: include/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// data path and address width
`define XLEN 32

// general purpose registers
`define REG_NUM 32
`define REG_IDX_W 5

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module decode_stage_tb -o decode_stage_sim

output=$(./obj_dir/decode_stage_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q 'All tests passed!'; then
    exit 0
else
    exit 1
fi

// File: src/decode_pipe_reg.sv
`default_nettype none

module decode_pipe_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        in_valid,
    input  decode_pkg::stage_bundle_t   in_bundle,
    input  logic                        out_ready,
    output logic                        out_valid,
    output decode_pkg::stage_bundle_t   out
);

    logic load;      // accept from fetch
    logic consume;   // execute takes the slot

    assign load = in_valid & out_ready;
    assign consume = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;   // flush wins over a same-edge load
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (consume) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (load) begin
            out <= in_bundle;
        end
        // otherwise hold, also under back-pressure
    end

endmodule

`default_nettype wire

// File: src/decode_pkg.sv
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

    // instruction word, one view per encoding format
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_r3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm20;
        logic [4:0]  rd;
    } fmt_ri20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;   // upper offset bits sit in the low field
    } fmt_i26_t;

    typedef union packed {
        fmt_r3_t   r3;
        fmt_ri12_t ri12;
        fmt_ri16_t ri16;
        fmt_ri20_t ri20;
        fmt_i26_t  i26;
    } inst_word_u;

    typedef enum logic [3:0] {
        alu_none, alu_add, alu_lui, alu_or, alu_sub, alu_xor, alu_sra,
        alu_and, alu_sll, alu_srl, alu_sltu, alu_nor, alu_slt
    } alu_op_e;

    typedef enum logic [2:0] {
        md_none, md_mul, md_mulh, md_mulhu, md_div, md_mod, md_divu, md_modu
    } md_op_e;

    typedef enum logic [3:0] {
        br_none, br_jirl, br_jump, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } branch_op_e;

    typedef enum logic [1:0] {
        size_byte, size_half, size_word
    } mem_size_e;

    typedef struct packed {
        logic      en;
        logic      store;   // 0 load, 1 store
        mem_size_e size;
        logic      zext;    // ld.bu / ld.hu
    } mem_op_t;

    typedef enum logic [1:0] {
        src_reg, src_imm, src_pc
    } src_sel_e;

    typedef enum logic [2:0] {
        imm_none, imm_si12, imm_ui12, imm_si16_s2, imm_si26_s2, imm_ui20_hi, imm_ui5
    } imm_kind_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        md_op_e                  md_op;
        branch_op_e              branch_op;
        mem_op_t                 mem_op;
        src_sel_e                src1_sel;
        src_sel_e                src2_sel;
        imm_kind_e               imm_kind;
        logic                    wreg_en;
        logic [`REG_IDX_W-1:0]   wreg_index;
        logic                    is_break;
        logic                    inst_valid;
    } ctrl_word_t;

    // content of the decode/execute stage register
    typedef struct packed {
        ctrl_word_t         ctrl;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   inst;
        logic [`XLEN-1:0]   src1_data;
        logic [`XLEN-1:0]   src2_data;
        logic [`XLEN-1:0]   imm;
    } stage_bundle_t;

endpackage

`default_nettype wire

// File: src/decode_stage.sv
`default_nettype none

`include "decode_macros.svh"

module decode_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    // fetch side
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`XLEN-1:0]            inst,
    input  logic [`XLEN-1:0]            pc,
    // execute side
    output logic                        out_valid,
    input  logic                        out_ready,
    output decode_pkg::stage_bundle_t   out,
    // writeback
    input  logic                        wb_en,
    input  logic [`REG_IDX_W-1:0]       wb_index,
    input  logic [`XLEN-1:0]            wb_data
);

    decode_pkg::inst_word_u     inst_word;
    decode_pkg::ctrl_word_t     ctrl;
    decode_pkg::stage_bundle_t  next_bundle;
    logic [`REG_IDX_W-1:0]      rd_index1;
    logic [`REG_IDX_W-1:0]      rd_index2;
    logic [`XLEN-1:0]           rd_data1;
    logic [`XLEN-1:0]           rd_data2;
    logic [`XLEN-1:0]           imm;

    assign inst_word = inst;
    assign in_ready = out_ready;   // single slot refills as it empties

    inst_decoder inst_decoder_inst (
        .inst      (inst_word),
        .ctrl      (ctrl),
        .rd_index1 (rd_index1),
        .rd_index2 (rd_index2)
    );

    imm_gen imm_gen_inst (
        .inst     (inst_word),
        .imm_kind (ctrl.imm_kind),
        .imm      (imm)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_index1 (rd_index1),
        .rd_index2 (rd_index2),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .wb_en     (wb_en),
        .wb_index  (wb_index),
        .wb_data   (wb_data)
    );

    assign next_bundle.ctrl = ctrl;
    assign next_bundle.pc = pc;
    assign next_bundle.inst = inst;
    assign next_bundle.src1_data = rd_data1;   // raw register values, selects applied in execute
    assign next_bundle.src2_data = rd_data2;
    assign next_bundle.imm = imm;

    decode_pipe_reg decode_pipe_reg_inst (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_bundle (next_bundle),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

// File: src/imm_gen.sv
`default_nettype none

`include "decode_macros.svh"

module imm_gen (
    input  decode_pkg::inst_word_u   inst,
    input  decode_pkg::imm_kind_e    imm_kind,
    output logic [`XLEN-1:0]         imm
);

    logic [25:0] offs26;

    // b / bl keep the high offset bits in the rd/rj field
    assign offs26 = {inst.i26.offs_hi, inst.i26.offs_lo};

    always_comb begin
        case (imm_kind)
            decode_pkg::imm_si12:
                imm = {{(`XLEN-12){inst.ri12.imm12[11]}}, inst.ri12.imm12};
            decode_pkg::imm_ui12:
                imm = {{(`XLEN-12){1'b0}}, inst.ri12.imm12};
            decode_pkg::imm_si16_s2:   // word offset
                imm = {{(`XLEN-18){inst.ri16.offs16[15]}}, inst.ri16.offs16, 2'b00};
            decode_pkg::imm_si26_s2:
                imm = {{(`XLEN-28){offs26[25]}}, offs26, 2'b00};
            decode_pkg::imm_ui20_hi:
                imm = {inst.ri20.imm20, {(`XLEN-20){1'b0}}};
            decode_pkg::imm_ui5:
                imm = {{(`XLEN-5){1'b0}}, inst.r3.rk};   // shift amount
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/inst_decoder.sv
`default_nettype none

`include "decode_macros.svh"

module inst_decoder (
    input  decode_pkg::inst_word_u   inst,
    output decode_pkg::ctrl_word_t   ctrl,
    output logic [`REG_IDX_W-1:0]    rd_index1,
    output logic [`REG_IDX_W-1:0]    rd_index2
);

    logic known;       // encoding matched
    logic no_wb;       // stores, plain branches, break
    logic rd_as_src2;  // stores and conditional branches read rd
    logic is_bl;

    always_comb begin
        ctrl = '0;
        known = 1'b1;
        no_wb = 1'b0;
        rd_as_src2 = 1'b0;
        is_bl = 1'b0;

        case (inst.ri16.opcode)
            6'h00: begin
                case (inst.r3.opcode)
                    17'h00020: ctrl.alu_op = decode_pkg::alu_add;
                    17'h00022: ctrl.alu_op = decode_pkg::alu_sub;
                    17'h00024: ctrl.alu_op = decode_pkg::alu_slt;
                    17'h00025: ctrl.alu_op = decode_pkg::alu_sltu;
                    17'h00028: ctrl.alu_op = decode_pkg::alu_nor;
                    17'h00029: ctrl.alu_op = decode_pkg::alu_and;
                    17'h0002a: ctrl.alu_op = decode_pkg::alu_or;
                    17'h0002b: ctrl.alu_op = decode_pkg::alu_xor;
                    17'h0002e: ctrl.alu_op = decode_pkg::alu_sll;
                    17'h0002f: ctrl.alu_op = decode_pkg::alu_srl;
                    17'h00030: ctrl.alu_op = decode_pkg::alu_sra;
                    17'h00038: ctrl.md_op = decode_pkg::md_mul;
                    17'h00039: ctrl.md_op = decode_pkg::md_mulh;
                    17'h0003a: ctrl.md_op = decode_pkg::md_mulhu;
                    17'h00040: ctrl.md_op = decode_pkg::md_div;
                    17'h00041: ctrl.md_op = decode_pkg::md_mod;
                    17'h00042: ctrl.md_op = decode_pkg::md_divu;
                    17'h00043: ctrl.md_op = decode_pkg::md_modu;
                    17'h00054: begin   // break
                        ctrl.is_break = 1'b1;
                        no_wb = 1'b1;
                    end
                    17'h00081, 17'h00089, 17'h00091: begin   // slli / srli / srai
                        ctrl.src2_sel = decode_pkg::src_imm;
                        ctrl.imm_kind = decode_pkg::imm_ui5;
                        if (inst.r3.opcode[3])
                            ctrl.alu_op = decode_pkg::alu_srl;
                        else if (inst.r3.opcode[4])
                            ctrl.alu_op = decode_pkg::alu_sra;
                        else
                            ctrl.alu_op = decode_pkg::alu_sll;
                    end
                    default: begin
                        // 12-bit immediate ALU group
                        ctrl.src2_sel = decode_pkg::src_imm;
                        ctrl.imm_kind = decode_pkg::imm_si12;
                        case (inst.ri12.opcode)
                            10'h008: ctrl.alu_op = decode_pkg::alu_slt;
                            10'h009: ctrl.alu_op = decode_pkg::alu_sltu;
                            10'h00a: ctrl.alu_op = decode_pkg::alu_add;
                            10'h00d: begin
                                ctrl.alu_op = decode_pkg::alu_and;
                                ctrl.imm_kind = decode_pkg::imm_ui12;
                            end
                            10'h00e: begin
                                ctrl.alu_op = decode_pkg::alu_or;
                                ctrl.imm_kind = decode_pkg::imm_ui12;
                            end
                            10'h00f: begin
                                ctrl.alu_op = decode_pkg::alu_xor;
                                ctrl.imm_kind = decode_pkg::imm_ui12;
                            end
                            default: begin
                                ctrl.src2_sel = decode_pkg::src_reg;
                                ctrl.imm_kind = decode_pkg::imm_none;
                                known = 1'b0;
                            end
                        endcase
                    end
                endcase
            end
            6'h0a: begin
                // loads and stores, address is rj + si12
                ctrl.alu_op = decode_pkg::alu_add;
                ctrl.src2_sel = decode_pkg::src_imm;
                ctrl.imm_kind = decode_pkg::imm_si12;
                ctrl.mem_op.en = 1'b1;
                ctrl.mem_op.store = inst.ri12.opcode[2];
                ctrl.mem_op.zext = inst.ri12.opcode[3];
                case (inst.ri12.opcode[1:0])
                    2'b00: ctrl.mem_op.size = decode_pkg::size_byte;
                    2'b01: ctrl.mem_op.size = decode_pkg::size_half;
                    default: ctrl.mem_op.size = decode_pkg::size_word;
                endcase
                case (inst.ri12.opcode[3:0])
                    4'h0, 4'h1, 4'h2, 4'h8, 4'h9: ;
                    4'h4, 4'h5, 4'h6: begin
                        no_wb = 1'b1;
                        rd_as_src2 = 1'b1;
                    end
                    default: begin
                        ctrl = '0;
                        known = 1'b0;
                    end
                endcase
            end
            6'h13: begin   // jirl, target rj + offs
                ctrl.alu_op = decode_pkg::alu_add;
                ctrl.branch_op = decode_pkg::br_jirl;
                ctrl.src2_sel = decode_pkg::src_imm;
                ctrl.imm_kind = decode_pkg::imm_si16_s2;
            end
            6'h14, 6'h15: begin   // b, bl
                ctrl.alu_op = decode_pkg::alu_add;
                ctrl.branch_op = decode_pkg::br_jump;
                ctrl.src1_sel = decode_pkg::src_pc;
                ctrl.src2_sel = decode_pkg::src_imm;
                ctrl.imm_kind = decode_pkg::imm_si26_s2;
                is_bl = inst.i26.opcode[0];
                no_wb = ~inst.i26.opcode[0];
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                ctrl.alu_op = decode_pkg::alu_add;
                ctrl.src1_sel = decode_pkg::src_pc;
                ctrl.src2_sel = decode_pkg::src_imm;
                ctrl.imm_kind = decode_pkg::imm_si16_s2;
                no_wb = 1'b1;
                rd_as_src2 = 1'b1;
                case (inst.ri16.opcode[2:0])
                    3'h6: ctrl.branch_op = decode_pkg::br_beq;
                    3'h7: ctrl.branch_op = decode_pkg::br_bne;
                    3'h0: ctrl.branch_op = decode_pkg::br_blt;
                    3'h1: ctrl.branch_op = decode_pkg::br_bge;
                    3'h2: ctrl.branch_op = decode_pkg::br_bltu;
                    default: ctrl.branch_op = decode_pkg::br_bgeu;
                endcase
            end
            default: begin
                case (inst.ri20.opcode)
                    7'h0a: begin   // lu12i
                        ctrl.alu_op = decode_pkg::alu_lui;
                        ctrl.src1_sel = decode_pkg::src_imm;
                        ctrl.src2_sel = decode_pkg::src_imm;
                        ctrl.imm_kind = decode_pkg::imm_ui20_hi;
                    end
                    7'h0e: begin   // pcaddu12i
                        ctrl.alu_op = decode_pkg::alu_add;
                        ctrl.src1_sel = decode_pkg::src_imm;
                        ctrl.src2_sel = decode_pkg::src_pc;
                        ctrl.imm_kind = decode_pkg::imm_ui20_hi;
                    end
                    default: known = 1'b0;
                endcase
            end
        endcase

        ctrl.inst_valid = known;
        ctrl.wreg_en = known & ~no_wb;
        ctrl.wreg_index = is_bl ? `REG_IDX_W'(1) : inst.r3.rd;   // bl links into r1
    end

    assign rd_index1 = inst.r3.rj;
    assign rd_index2 = rd_as_src2 ? inst.r3.rd : inst.r3.rk;

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

`include "decode_macros.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_IDX_W-1:0]   rd_index1,
    input  logic [`REG_IDX_W-1:0]   rd_index2,
    output logic [`XLEN-1:0]        rd_data1,
    output logic [`XLEN-1:0]        rd_data2,
    input  logic                    wb_en,
    input  logic [`REG_IDX_W-1:0]   wb_index,
    input  logic [`XLEN-1:0]        wb_data
);

    logic [`XLEN-1:0] regs [1:`REG_NUM-1];   // no storage for r0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_index != '0)) begin
            regs[wb_index] <= wb_data;
        end
    end

    // no write bypass, new value visible next cycle
    assign rd_data1 = (rd_index1 == '0) ? '0 : regs[rd_index1];
    assign rd_data2 = (rd_index2 == '0) ? '0 : regs[rd_index2];

endmodule

`default_nettype wire

// File: tb/decode_stage_tb.sv
`default_nettype none

`include "decode_macros.svh"

module decode_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 8;
    localparam int num_ops = 70;   // register writes plus issued instructions

    logic                       clk;
    logic                       reset;
    logic                       flush;
    logic                       in_valid;
    logic                       in_ready;
    logic [`XLEN-1:0]           inst;
    logic [`XLEN-1:0]           pc;
    logic                       out_valid;
    logic                       out_ready;
    decode_pkg::stage_bundle_t  out_bundle;
    logic                       wb_en;
    logic [`REG_IDX_W-1:0]      wb_index;
    logic [`XLEN-1:0]           wb_data;

    logic [`XLEN-1:0] mirror [0:`REG_NUM-1];   // expected register contents
    integer seed;

    decode_stage decode_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .pc        (pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out_bundle),
        .wb_en     (wb_en),
        .wb_index  (wb_index),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(num_ops * 200 * clk_period);
        $display("Timeout: the DUT stopped answering the handshake");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    // instruction encoders, one per format
    function automatic logic [31:0] r3_word(input logic [16:0] op, input logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [11:0] imm,
                                              input logic [4:0] rj, rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] ri16_word(input logic [5:0] op, input logic [15:0] offs,
                                              input logic [4:0] rj, rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] ri20_word(input logic [6:0] op, input logic [19:0] imm,
                                              input logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    function automatic logic [31:0] i26_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};   // high part goes in the low bits
    endfunction

    task automatic fill_registers();
        for (int i = 0; i < `REG_NUM; i++) begin
            wb_en = 1'b1;
            wb_index = 5'(i);
            wb_data = $random(seed);
            mirror[i] = (i == 0) ? '0 : wb_data;   // write to r0 is dropped
            @(posedge clk);
            #1;
        end
        wb_en = 1'b0;
    endtask

    // issue one instruction, then hold the result with out_ready low
    task automatic send_inst(input logic [31:0] word, input logic [31:0] addr);
        inst = word;
        pc = addr;
        in_valid = 1'b1;
        out_ready = 1'b1;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
        #1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        while (!out_valid) begin
            @(posedge clk);
            #1;
        end
        compare("inst field", word, out_bundle.inst);
        compare("pc field", addr, out_bundle.pc);
    endtask

    task automatic expect_ctrl(input string name, input decode_pkg::alu_op_e alu,
                               input decode_pkg::md_op_e md, input decode_pkg::branch_op_e br,
                               input logic wen, input logic [4:0] widx);
        compare(name, 32'(alu), 32'(out_bundle.ctrl.alu_op));
        compare(name, 32'(md), 32'(out_bundle.ctrl.md_op));
        compare(name, 32'(br), 32'(out_bundle.ctrl.branch_op));
        compare(name, 32'(wen), 32'(out_bundle.ctrl.wreg_en));
        compare(name, 32'(widx), 32'(out_bundle.ctrl.wreg_index));
        compare(name, 32'd1, 32'(out_bundle.ctrl.inst_valid));
    endtask

    task automatic reset_and_backpressure();
        decode_pkg::stage_bundle_t held;
        compare("reset valid", 32'd0, 32'(out_valid));
        compare("reset bundle", 32'd1, 32'(out_bundle == '0));
        out_ready = 1'b0;
        #1;
        compare("in_ready low", 32'd0, 32'(in_ready));
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        #1;
        compare("in_ready high", 32'd1, 32'(in_ready));
        @(posedge clk);
        #1;
        send_inst(r3_word(17'h00020, 5'd2, 5'd3, 5'd4), 32'h1c00_0000);   // add
        held = out_bundle;
        compare("held op", 32'(decode_pkg::alu_add), 32'(held.ctrl.alu_op));
        inst = r3_word(17'h00022, 5'd5, 5'd6, 5'd7);   // sub waits behind it
        in_valid = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            compare("hold valid", 32'd1, 32'(out_valid));
            compare("hold bundle", 32'd1, 32'(out_bundle == held));
        end
        in_valid = 1'b0;
        out_ready = 1'b1;
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        compare("drain once", 32'd0, 32'(out_valid));
    endtask

    task automatic reg_op(input string name, input logic [16:0] op,
                          input decode_pkg::alu_op_e alu, input decode_pkg::md_op_e md,
                          input logic [4:0] rk, rj, rd);
        send_inst(r3_word(op, rk, rj, rd), 32'h1c00_0040);
        expect_ctrl(name, alu, md, decode_pkg::br_none, 1'b1, rd);
        compare(name, mirror[rj], out_bundle.src1_data);
        compare(name, mirror[rk], out_bundle.src2_data);
    endtask

    task automatic register_ops();
        reg_op("add", 17'h00020, decode_pkg::alu_add, decode_pkg::md_none, 5'd1, 5'd2, 5'd3);
        reg_op("sub", 17'h00022, decode_pkg::alu_sub, decode_pkg::md_none, 5'd4, 5'd5, 5'd6);
        reg_op("slt", 17'h00024, decode_pkg::alu_slt, decode_pkg::md_none, 5'd7, 5'd8, 5'd9);
        reg_op("nor", 17'h00028, decode_pkg::alu_nor, decode_pkg::md_none, 5'd10, 5'd11, 5'd12);
        reg_op("sll", 17'h0002e, decode_pkg::alu_sll, decode_pkg::md_none, 5'd13, 5'd14, 5'd15);
        reg_op("mul", 17'h00038, decode_pkg::alu_none, decode_pkg::md_mul, 5'd16, 5'd17, 5'd18);
        reg_op("mulh", 17'h00039, decode_pkg::alu_none, decode_pkg::md_mulh, 5'd19, 5'd20, 5'd21);
        reg_op("divu", 17'h00042, decode_pkg::alu_none, decode_pkg::md_divu, 5'd22, 5'd23, 5'd24);
        reg_op("modu", 17'h00043, decode_pkg::alu_none, decode_pkg::md_modu, 5'd25, 5'd26, 5'd27);
        reg_op("add r0", 17'h00020, decode_pkg::alu_add, decode_pkg::md_none, 5'd0, 5'd0, 5'd31);
    endtask

    task automatic immediate_forms();
        send_inst(ri12_word(10'h00a, 12'hffd, 5'd6, 5'd5), 32'h1c00_0100);
        expect_ctrl("addi", decode_pkg::alu_add, decode_pkg::md_none, decode_pkg::br_none,
                    1'b1, 5'd5);
        compare("addi", 32'hffff_fffd, out_bundle.imm);   // sign extended
        send_inst(ri12_word(10'h00d, 12'h8f0, 5'd6, 5'd5), 32'h1c00_0104);
        compare("andi", 32'h0000_08f0, out_bundle.imm);
        send_inst(ri12_word(10'h00e, 12'hfff, 5'd6, 5'd5), 32'h1c00_0108);
        compare("ori", 32'h0000_0fff, out_bundle.imm);
        send_inst(ri20_word(7'h0a, 20'h81234, 5'd7), 32'h1c00_010c);
        expect_ctrl("lu12i", decode_pkg::alu_lui, decode_pkg::md_none, decode_pkg::br_none,
                    1'b1, 5'd7);
        compare("lu12i", 32'h8123_4000, out_bundle.imm);
        compare("lu12i src1", 32'(decode_pkg::src_imm), 32'(out_bundle.ctrl.src1_sel));
        compare("lu12i src2", 32'(decode_pkg::src_imm), 32'(out_bundle.ctrl.src2_sel));
        send_inst(ri20_word(7'h0e, 20'h00abc, 5'd8), 32'h1c00_0200);
        compare("pcaddu12i", 32'h00ab_c000, out_bundle.imm);
        compare("pcaddu12i pc", 32'h1c00_0200, out_bundle.pc);
        compare("pcaddu12i src1", 32'(decode_pkg::src_imm), 32'(out_bundle.ctrl.src1_sel));
        compare("pcaddu12i src2", 32'(decode_pkg::src_pc), 32'(out_bundle.ctrl.src2_sel));
        send_inst(r3_word(17'h00081, 5'd17, 5'd9, 5'd10), 32'h1c00_0204);
        expect_ctrl("slli", decode_pkg::alu_sll, decode_pkg::md_none, decode_pkg::br_none,
                    1'b1, 5'd10);
        compare("slli", 32'd17, out_bundle.imm);
        compare("slli kind", 32'(decode_pkg::imm_ui5), 32'(out_bundle.ctrl.imm_kind));
        send_inst(ri16_word(6'h16, 16'hfffe, 5'd11, 5'd12), 32'h1c00_0208);
        expect_ctrl("beq", decode_pkg::alu_add, decode_pkg::md_none, decode_pkg::br_beq,
                    1'b0, 5'd12);
        compare("beq", 32'hffff_fff8, out_bundle.imm);
        compare("beq src1", 32'(decode_pkg::src_pc), 32'(out_bundle.ctrl.src1_sel));
        compare("beq rd data", mirror[12], out_bundle.src2_data);
        send_inst(ri16_word(6'h13, 16'h0010, 5'd13, 5'd14), 32'h1c00_020c);
        expect_ctrl("jirl", decode_pkg::alu_add, decode_pkg::md_none, decode_pkg::br_jirl,
                    1'b1, 5'd14);
        compare("jirl", 32'h0000_0040, out_bundle.imm);
        compare("jirl rj data", mirror[13], out_bundle.src1_data);
        send_inst(i26_word(6'h14, 26'h200_0001), 32'h1c00_0210);
        expect_ctrl("b", decode_pkg::alu_add, decode_pkg::md_none, decode_pkg::br_jump,
                    1'b0, 5'd0);
        compare("b", 32'hf800_0004, out_bundle.imm);
        send_inst(i26_word(6'h15, 26'h000_0100), 32'h1c00_0214);
        expect_ctrl("bl", decode_pkg::alu_add, decode_pkg::md_none, decode_pkg::br_jump,
                    1'b1, 5'd1);
        compare("bl", 32'h0000_0400, out_bundle.imm);
    endtask

    task automatic mem_case(input string name, input logic [9:0] op,
                            input decode_pkg::mem_size_e size, input logic store, zext);
        send_inst(ri12_word(op, 12'h804, 5'd15, 5'd16), 32'h1c00_0300);
        expect_ctrl(name, decode_pkg::alu_add, decode_pkg::md_none, decode_pkg::br_none,
                    ~store, 5'd16);
        compare(name, {27'd0, 1'b1, store, 2'(size), zext}, 32'(out_bundle.ctrl.mem_op));
        compare(name, 32'hffff_f804, out_bundle.imm);
        if (store) begin
            compare(name, mirror[16], out_bundle.src2_data);   // store data comes from rd
        end
    endtask

    task automatic memory_ops();
        mem_case("ld.b", 10'h0a0, decode_pkg::size_byte, 1'b0, 1'b0);
        mem_case("ld.bu", 10'h0a8, decode_pkg::size_byte, 1'b0, 1'b1);
        mem_case("ld.h", 10'h0a1, decode_pkg::size_half, 1'b0, 1'b0);
        mem_case("ld.hu", 10'h0a9, decode_pkg::size_half, 1'b0, 1'b1);
        mem_case("ld.w", 10'h0a2, decode_pkg::size_word, 1'b0, 1'b0);
        mem_case("st.b", 10'h0a4, decode_pkg::size_byte, 1'b1, 1'b0);
        mem_case("st.h", 10'h0a5, decode_pkg::size_half, 1'b1, 1'b0);
        mem_case("st.w", 10'h0a6, decode_pkg::size_word, 1'b1, 1'b0);
    endtask

    task automatic flush_latency();
        inst = r3_word(17'h0002b, 5'd18, 5'd19, 5'd20);   // xor
        pc = 32'h1c00_0400;
        in_valid = 1'b1;
        out_ready = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        flush = 1'b1;
        compare("latency valid", 32'd1, 32'(out_valid));   // one cycle after accept
        compare("latency op", 32'(decode_pkg::alu_xor), 32'(out_bundle.ctrl.alu_op));
        @(posedge clk);
        #1;
        flush = 1'b0;
        compare("flush", 32'd0, 32'(out_valid));
        @(posedge clk);
        #1;
        compare("flush stays", 32'd0, 32'(out_valid));
    endtask

    task automatic illegal_and_break();
        send_inst(32'hfc00_0000, 32'h1c00_0500);
        compare("illegal valid", 32'd0, 32'(out_bundle.ctrl.inst_valid));
        compare("illegal wreg", 32'd0, 32'(out_bundle.ctrl.wreg_en));
        send_inst(32'h0000_0000, 32'h1c00_0504);
        compare("zero word valid", 32'd0, 32'(out_bundle.ctrl.inst_valid));
        compare("zero word wreg", 32'd0, 32'(out_bundle.ctrl.wreg_en));
        send_inst(r3_word(17'h00054, 5'd0, 5'd0, 5'd0), 32'h1c00_0508);
        compare("break flag", 32'd1, 32'(out_bundle.ctrl.is_break));
        compare("break valid", 32'd1, 32'(out_bundle.ctrl.inst_valid));
        compare("break wreg", 32'd0, 32'(out_bundle.ctrl.wreg_en));
    endtask

    initial begin
        seed = 32'hd2ef;
        reset = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        inst = '0;
        pc = '0;
        out_ready = 1'b0;
        wb_en = 1'b0;
        wb_index = '0;
        wb_data = '0;
        mirror[0] = '0;   // r0 reads zero
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_and_backpressure();
        fill_registers();
        register_ops();
        immediate_forms();
        memory_ops();
        flush_latency();
        illegal_and_break();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
src/decode_pkg.sv
src/inst_decoder.sv
src/imm_gen.sv
src/reg_file.sv
src/decode_pipe_reg.sv
src/decode_stage.sv
tb/decode_stage_tb.sv
